// File: rtl/capPkg.sv
////////////////////////////////////////////////////////////
// Parity-protected memory wrapper, shared definitions
// Sizes, opcode and FSM state enums, and the request and
// response structs used across the wrapper and its testbench
////////////////////////////////////////////////////////////

package capPkg;

   ////////////////////////////////////////////////////////////
   // Sizes
   ////////////////////////////////////////////////////////////

   // Payload width of one word
   localparam int DATA_WIDTH = 32;
   // Word address width
   localparam int ADDR_WIDTH = 6;
   // Number of words in the storage array
   localparam int DEPTH      = 64;
   // Error counter width, saturates at all ones
   localparam int CNT_WIDTH  = 8;
   // Stored word is data plus one even-parity bit on top
   localparam int WORD_WIDTH = DATA_WIDTH + 1;

   ////////////////////////////////////////////////////////////
   // Enums
   ////////////////////////////////////////////////////////////

   // Request opcode
   // OP_INJECT writes the word with its parity bit inverted
   typedef enum logic [1:0] {
      OP_READ   = 2'd0,
      OP_WRITE  = 2'd1,
      OP_INJECT = 2'd2
   } capOpT;

   // Control FSM states
   typedef enum logic [1:0] {
      CS_IDLE = 2'd0,
      CS_READ = 2'd1,
      CS_RESP = 2'd2
   } ctrlStateT;

   ////////////////////////////////////////////////////////////
   // Request and response payloads
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      capOpT                 op;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] data;
   } capReqT;

   // Writes echo the written data, parErr only ever set on reads
   typedef struct packed {
      capOpT                 op;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] data;
      logic                  parErr;
   } capRspT;

endpackage

// File: rtl/CapMemArray.sv
////////////////////////////////////////////////////////////
// Storage array with parity encode on write
// Parity can be inverted per write for error injection,
// read data is registered one cycle after the read strobe
////////////////////////////////////////////////////////////

module CapMemArray (
   input  logic                          clk,
   input  logic                          memWe,
   input  logic                          memInvPar,
   input  logic                          memRe,
   input  logic [capPkg::ADDR_WIDTH-1:0] memAddr,
   input  logic [capPkg::DATA_WIDTH-1:0] memWdata,
   output logic [capPkg::WORD_WIDTH-1:0] memRdata
);

   import capPkg::*;

   // Storage, no reset like a real RAM macro
   logic [WORD_WIDTH-1:0] mem [DEPTH];

   // Encoded write word
   logic                  wrParity;
   logic [WORD_WIDTH-1:0] wrWord;

   ////////////////////////////////////////////////////////////
   // Parity encode
   ////////////////////////////////////////////////////////////

   // Even parity over the payload
   // Flipped on an inject so the whole stored word goes odd
   assign wrParity = (^memWdata) ^ memInvPar;

   // Parity bit sits on top, same layout the checker expects
   assign wrWord = {wrParity, memWdata};

   ////////////////////////////////////////////////////////////
   // Write port
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (memWe) begin
         mem[memAddr] <= wrWord;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read port
   ////////////////////////////////////////////////////////////

   // Registered read, output holds between strobes
   always_ff @(posedge clk) begin
      if (memRe) begin
         memRdata <= mem[memAddr];
      end
   end

endmodule

// File: rtl/CapParityCkr.sv
////////////////////////////////////////////////////////////
// Parity checker
// Splits a stored word into payload and parity bit and
// flags odd parity unless checking is disabled
////////////////////////////////////////////////////////////

module CapParityCkr #(
   parameter int WIDTH = 8
) (
   input  logic [WIDTH:0]   parityDataIn,
   input  logic             protChkDisable,
   output logic [WIDTH-1:0] rawDataOut,
   output logic             parityOut,
   output logic             parErr
);

   // Whole word reduces to 0 for good even parity
   logic wordOdd;

   assign wordOdd = ^parityDataIn;

   // Mismatch, masked at run time by the disable input
   assign parErr = wordOdd && !protChkDisable;

   // Parity bit is the top bit of the stored word
   assign parityOut = parityDataIn[WIDTH];

   // Payload passes straight through
   assign rawDataOut = parityDataIn[WIDTH-1:0];

endmodule

// File: rtl/CapMemCtrl.sv
////////////////////////////////////////////////////////////
// Memory wrapper control
// Accepts one request at a time, sequences the array,
// holds the response under back-pressure and reports
// parity errors on read hand-off
////////////////////////////////////////////////////////////

module CapMemCtrl (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          reqValid,
   output logic                          reqReady,
   input  capPkg::capReqT                req,
   output logic                          rspValid,
   input  logic                          rspReady,
   output capPkg::capRspT                rsp,
   output logic                          memWe,
   output logic                          memInvPar,
   output logic                          memRe,
   output logic [capPkg::ADDR_WIDTH-1:0] memAddr,
   output logic [capPkg::DATA_WIDTH-1:0] memWdata,
   input  logic [capPkg::DATA_WIDTH-1:0] rawData,
   input  logic                          parErr,
   output logic                          errEvent,
   output logic [capPkg::ADDR_WIDTH-1:0] errAddr
);

   import capPkg::*;

   ctrlStateT state;

   // Accepted request, drives the array port while busy
   capReqT    reqQ;

   logic      reqFire;
   logic      rspFire;
   // Read data from the array is valid this cycle
   logic      rdDataVld;

   ////////////////////////////////////////////////////////////
   // Handshakes
   ////////////////////////////////////////////////////////////

   // One request in flight, so only accept when idle
   assign reqReady  = (state == CS_IDLE);
   assign reqFire   = reqValid && reqReady;
   assign rspFire   = rspValid && rspReady;

   // Strobe cycle is over once memRe has dropped
   assign rdDataVld = (state == CS_READ) && !memRe;

   // Array port comes from the latched request
   assign memAddr   = reqQ.addr;
   assign memWdata  = reqQ.data;
   assign memInvPar = memWe && (reqQ.op == OP_INJECT);

   // Error pulse lines up with the hand-off of a bad read
   assign errEvent  = rspFire && rsp.parErr;
   assign errAddr   = rsp.addr;

   ////////////////////////////////////////////////////////////
   // Control FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state    <= CS_IDLE;
         rspValid <= 1'b0;
         memWe    <= 1'b0;
         memRe    <= 1'b0;
      end else begin
         // Array strobes are single-cycle pulses
         memWe <= 1'b0;
         memRe <= 1'b0;
         case (state)
            CS_IDLE: begin
               if (reqFire) begin
                  if (req.op == OP_READ) begin
                     memRe <= 1'b1;
                     state <= CS_READ;
                  end else begin
                     // Write or inject goes straight to response
                     memWe <= 1'b1;
                     state <= CS_RESP;
                  end
               end
            end
            CS_READ: begin
               // Second cycle, checker output gets registered
               if (rdDataVld) begin
                  rspValid <= 1'b1;
                  state    <= CS_RESP;
               end
            end
            CS_RESP: begin
               if (!rspValid) begin
                  // Write lands in the array this edge
                  rspValid <= 1'b1;
               end else if (rspReady) begin
                  rspValid <= 1'b0;
                  state    <= CS_IDLE;
               end
            end
            default: begin
               state <= CS_IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Request and response payload
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reqFire) begin
         reqQ <= req;
      end
      // Write response echoes the request, never an error
      if (reqFire && (req.op != OP_READ)) begin
         rsp.op     <= req.op;
         rsp.addr   <= req.addr;
         rsp.data   <= req.data;
         rsp.parErr <= 1'b0;
      end else if (rdDataVld) begin
         rsp.op     <= reqQ.op;
         rsp.addr   <= reqQ.addr;
         rsp.data   <= rawData;
         rsp.parErr <= parErr;
      end
   end

endmodule

// File: rtl/CapErrLog.sv
////////////////////////////////////////////////////////////
// Parity error logger
// Saturating event counter, sticky flag and address of the
// first error since reset or the last clear
////////////////////////////////////////////////////////////

module CapErrLog (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          errEvent,
   input  logic [capPkg::ADDR_WIDTH-1:0] errAddr,
   input  logic                          errClear,
   output logic [capPkg::CNT_WIDTH-1:0]  errCount,
   output logic                          errSticky,
   output logic [capPkg::ADDR_WIDTH-1:0] firstErrAddr
);

   import capPkg::*;

   // Counter has hit all ones
   logic cntSat;

   assign cntSat = (errCount == {CNT_WIDTH{1'b1}});

   ////////////////////////////////////////////////////////////
   // Counter and flags
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rstN) begin
         errCount     <= '0;
         errSticky    <= 1'b0;
         firstErrAddr <= '0;
      end else if (errClear) begin
         // Clear wins over an event in the same cycle
         errCount     <= '0;
         errSticky    <= 1'b0;
         firstErrAddr <= '0;
      end else if (errEvent) begin
         if (!cntSat) begin
            errCount <= errCount + 1'b1;
         end
         // Only the first event since clear is captured
         if (!errSticky) begin
            firstErrAddr <= errAddr;
         end
         errSticky <= 1'b1;
      end
   end

endmodule

// File: rtl/CapMemTop.sv
////////////////////////////////////////////////////////////
// Parity-protected memory wrapper, top level
// Control, storage array, parity checker and error logger
////////////////////////////////////////////////////////////

module CapMemTop (
   input  logic                          clk,
   input  logic                          rstN,
   // Request port
   input  logic                          reqValid,
   output logic                          reqReady,
   input  capPkg::capReqT                req,
   // Response port
   output logic                          rspValid,
   input  logic                          rspReady,
   output capPkg::capRspT                rsp,
   // Protection control and error status
   input  logic                          protChkDisable,
   input  logic                          errClear,
   output logic [capPkg::CNT_WIDTH-1:0]  errCount,
   output logic                          errSticky,
   output logic [capPkg::ADDR_WIDTH-1:0] firstErrAddr
);

   import capPkg::*;

   ////////////////////////////////////////////////////////////
   // Internal wiring
   ////////////////////////////////////////////////////////////

   // Array port
   logic                  memWe;
   logic                  memInvPar;
   logic                  memRe;
   logic [ADDR_WIDTH-1:0] memAddr;
   logic [DATA_WIDTH-1:0] memWdata;
   logic [WORD_WIDTH-1:0] memRdata;

   // Checker results
   logic [DATA_WIDTH-1:0] rawData;
   logic                  parErr;

   // Error report to the logger
   logic                  errEvent;
   logic [ADDR_WIDTH-1:0] errAddr;

   CapMemCtrl u_CapMemCtrl (
      .clk      (clk),
      .rstN     (rstN),
      .reqValid (reqValid),
      .reqReady (reqReady),
      .req      (req),
      .rspValid (rspValid),
      .rspReady (rspReady),
      .rsp      (rsp),
      .memWe    (memWe),
      .memInvPar(memInvPar),
      .memRe    (memRe),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .rawData  (rawData),
      .parErr   (parErr),
      .errEvent (errEvent),
      .errAddr  (errAddr)
   );

   CapMemArray u_CapMemArray (
      .clk      (clk),
      .memWe    (memWe),
      .memInvPar(memInvPar),
      .memRe    (memRe),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memRdata (memRdata)
   );

   // Parity bit itself is not needed past the checker
   CapParityCkr #(
      .WIDTH(DATA_WIDTH)
   ) u_CapParityCkr (
      .parityDataIn  (memRdata),
      .protChkDisable(protChkDisable),
      .rawDataOut    (rawData),
      .parityOut     (),
      .parErr        (parErr)
   );

   CapErrLog u_CapErrLog (
      .clk         (clk),
      .rstN        (rstN),
      .errEvent    (errEvent),
      .errAddr     (errAddr),
      .errClear    (errClear),
      .errCount    (errCount),
      .errSticky   (errSticky),
      .firstErrAddr(firstErrAddr)
   );

endmodule

// File: sim/capChecker.sv
////////////////////////////////////////////////////////////
// Response and error logger monitor
// Checks each response hand-off against the expected queue,
// the hold rules under back-pressure and the logger outputs
////////////////////////////////////////////////////////////

module capChecker (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          reqValid,
   input  logic                          reqReady,
   input  logic                          rspValid,
   input  logic                          rspReady,
   input  capPkg::capRspT                rsp,
   input  logic                          errClear,
   input  logic [capPkg::CNT_WIDTH-1:0]  errCount,
   input  logic                          errSticky,
   input  logic [capPkg::ADDR_WIDTH-1:0] firstErrAddr,
   input  logic                          expValid,
   input  capPkg::capRspT                expRsp,
   output int                            errorCnt,
   output int                            pendingCnt
);

   import capPkg::*;

   // Expected responses in request order
   capRspT                expQ[$];
   capRspT                want;
   capRspT                heldRsp;
   logic                  stallPrev;
   logic                  busy;
   logic                  errHit;
   // Expected logger state
   logic [CNT_WIDTH-1:0]  mCount;
   logic                  mSticky;
   logic [ADDR_WIDTH-1:0] mFirst;

   initial begin
      errorCnt   = 0;
      pendingCnt = 0;
   end

   task automatic compareValue(input string name, input logic [63:0] wantV,
                               input logic [63:0] gotV);
      if (gotV !== wantV) begin
         $display("** Error %s: expected %h, got %h at %0t", name, wantV, gotV, $time);
         errorCnt++;
      end
   endtask

   task automatic reportFault(input string msg);
      $display("%s at %0t", msg, $time);
      errorCnt++;
   endtask

   ////////////////////////////////////////////////////////////
   // Per-edge checks
   ////////////////////////////////////////////////////////////

   // DUT outputs are registered, read here before they update
   always @(posedge clk) begin
      if (!rstN) begin
         expQ.delete();
         stallPrev = 1'b0;
         busy      = 1'b0;
         mCount    = '0;
         mSticky   = 1'b0;
         mFirst    = '0;
      end else begin
         if (expValid) begin
            expQ.push_back(expRsp);
         end
         // Logger against the model before this edge
         compareValue("errCount", 64'(mCount), 64'(errCount));
         compareValue("errSticky", 64'(mSticky), 64'(errSticky));
         compareValue("firstErrAddr", 64'(mFirst), 64'(firstErrAddr));
         if (busy && reqReady) begin
            reportFault("reqReady rose before the response transfer");
         end
         // Stalled response must not move
         if (stallPrev) begin
            if (!rspValid) begin
               reportFault("rspValid dropped without a transfer");
            end else begin
               compareValue("rsp (held)", 64'(heldRsp), 64'(rsp));
            end
         end
         errHit = 1'b0;
         if (rspValid && rspReady) begin
            if (expQ.size() == 0) begin
               reportFault("Response handed off with no request pending");
            end else begin
               want = expQ.pop_front();
               compareValue("rsp.op", 64'(want.op), 64'(rsp.op));
               compareValue("rsp.addr", 64'(want.addr), 64'(rsp.addr));
               compareValue("rsp.data", 64'(want.data), 64'(rsp.data));
               compareValue("rsp.parErr", 64'(want.parErr), 64'(rsp.parErr));
               errHit = want.parErr;
            end
            busy = 1'b0;
         end
         if (reqValid && reqReady) begin
            busy = 1'b1;
         end
         stallPrev = rspValid && !rspReady;
         heldRsp   = rsp;
         // Logger model, clear beats an event on the same edge
         if (errClear) begin
            mCount  = '0;
            mSticky = 1'b0;
            mFirst  = '0;
         end else if (errHit) begin
            if (mCount != '1) begin
               mCount = mCount + CNT_WIDTH'(1);
            end
            if (!mSticky) begin
               mFirst = want.addr;
            end
            mSticky = 1'b1;
         end
      end
      pendingCnt = expQ.size();
   end

endmodule

// File: sim/tbCapMem.sv
////////////////////////////////////////////////////////////
// Testbench for the parity-protected memory wrapper
// Seeded random requests, reference memory model, random
// response back-pressure and a run watchdog
////////////////////////////////////////////////////////////

module tbCapMem;

   import capPkg::*;

   localparam int CLK_HALF        = 2;
   localparam int RESET_CYCLES    = 8;
   // Request counts per test
   localparam int N_PAIRS         = 40;
   localparam int N_INJ           = 8;
   localparam int N_SAT           = 260;
   localparam int N_RAND          = 300;
   localparam int TOTAL_REQS      = 2 * N_PAIRS + 5 * N_INJ + 1 + N_SAT + N_RAND;
   // Budget per request covers back-pressure stalls
   localparam int WATCHDOG_CYCLES = TOTAL_REQS * 20 + RESET_CYCLES;

   logic                  clk;
   logic                  rstN;
   logic                  reqValid;
   logic                  reqReady;
   capReqT                req;
   logic                  rspValid;
   logic                  rspReady;
   capRspT                rsp;
   logic                  protChkDisable;
   logic                  errClear;
   logic [CNT_WIDTH-1:0]  errCount;
   logic                  errSticky;
   logic [ADDR_WIDTH-1:0] firstErrAddr;
   // Expected response handed to the monitor
   logic                  expValid;
   capRspT                expRsp;
   int                    chkErrors;
   int                    pendingCnt;

   integer                seed;
   logic                  clrRandom;
   int                    tbErrors;
   int                    testNum;
   int                    testReqs;
   int                    totalReqs;
   int                    errStart;

   // Reference memory model
   logic                  mWritten [DEPTH];
   logic [DATA_WIDTH-1:0] mData    [DEPTH];
   logic                  mBad     [DEPTH];
   logic [ADDR_WIDTH-1:0] injAddr  [N_INJ];

   always #CLK_HALF clk = ~clk;

   CapMemTop u_CapMemTop (
      .clk(clk), .rstN(rstN),
      .reqValid(reqValid), .reqReady(reqReady), .req(req),
      .rspValid(rspValid), .rspReady(rspReady), .rsp(rsp),
      .protChkDisable(protChkDisable), .errClear(errClear),
      .errCount(errCount), .errSticky(errSticky), .firstErrAddr(firstErrAddr)
   );

   capChecker u_capChecker (
      .clk(clk), .rstN(rstN), .reqValid(reqValid), .reqReady(reqReady),
      .rspValid(rspValid), .rspReady(rspReady), .rsp(rsp), .errClear(errClear),
      .errCount(errCount), .errSticky(errSticky), .firstErrAddr(firstErrAddr),
      .expValid(expValid), .expRsp(expRsp),
      .errorCnt(chkErrors), .pendingCnt(pendingCnt)
   );

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////

   // Next falling edge, new random back-pressure
   task automatic stepNeg();
      @(negedge clk);
      rspReady = ($random(seed) & 3) != 0;
      if (clrRandom) begin
         errClear = ($random(seed) & 63) == 0;
      end
   endtask

   // Waits for idle, updates the model, presents one request
   task automatic sendRequest(input capOpT op, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] data, input logic pcd);
      capRspT want;
      while (!reqReady) begin
         stepNeg();
      end
      want.op   = op;
      want.addr = addr;
      if (op == OP_READ) begin
         want.data   = mData[addr];
         want.parErr = mBad[addr] && !pcd;
      end else begin
         want.data      = data;
         want.parErr    = 1'b0;
         mWritten[addr] = 1'b1;
         mData[addr]    = data;
         mBad[addr]     = (op == OP_INJECT);
      end
      req            = '{op: op, addr: addr, data: data};
      protChkDisable = pcd;
      reqValid       = 1'b1;
      expValid       = 1'b1;
      expRsp         = want;
      // Idle DUT takes it on the next rising edge
      stepNeg();
      reqValid = 1'b0;
      expValid = 1'b0;
      testReqs++;
      totalReqs++;
   endtask

   task automatic pulseClear();
      errClear = 1'b1;
      stepNeg();
      errClear = 1'b0;
   endtask

   task automatic startTest();
      testNum++;
      testReqs = 0;
      errStart = chkErrors + tbErrors;
   endtask

   // Drain the last response and let the logger settle
   task automatic finishTest(input string name);
      while (!reqReady) begin
         stepNeg();
      end
      stepNeg();
      stepNeg();
      $display("Test %0d %s: %0d requests, %0d errors", testNum, name, testReqs,
               chkErrors + tbErrors - errStart);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      logic [ADDR_WIDTH-1:0] a;
      logic [DATA_WIDTH-1:0] d;
      capOpT                 op;
      int                    i;
      int                    k;
      seed           = 39;
      clk            = 1'b0;
      rstN           = 1'b0;
      reqValid       = 1'b0;
      req            = '0;
      rspReady       = 1'b0;
      protChkDisable = 1'b0;
      errClear       = 1'b0;
      expValid       = 1'b0;
      expRsp         = '0;
      clrRandom      = 1'b0;
      tbErrors       = 0;
      testNum        = 0;
      totalReqs      = 0;
      for (i = 0; i < DEPTH; i++) begin
         mWritten[i] = 1'b0;
         mData[i]    = '0;
         mBad[i]     = 1'b0;
      end
      repeat (RESET_CYCLES) @(negedge clk);
      rstN = 1'b1;
      stepNeg();

      startTest();
      for (i = 0; i < N_PAIRS; i++) begin
         a = ADDR_WIDTH'($random(seed));
         d = $random(seed);
         sendRequest(OP_WRITE, a, d, 1'b0);
         sendRequest(OP_READ, a, $random(seed), 1'b0);
      end
      finishTest("write then read");

      // Injected words read with checking on, then masked
      startTest();
      for (i = 0; i < N_INJ; i++) begin
         injAddr[i] = ADDR_WIDTH'($random(seed));
         sendRequest(OP_INJECT, injAddr[i], $random(seed), 1'b0);
         sendRequest(OP_READ, injAddr[i], '0, 1'b0);
         sendRequest(OP_READ, injAddr[i], '0, 1'b1);
      end
      finishTest("inject and disable");

      startTest();
      for (i = 0; i < N_INJ; i++) begin
         sendRequest(OP_WRITE, injAddr[i], $random(seed), 1'b0);
         sendRequest(OP_READ, injAddr[i], '0, 1'b0);
      end
      finishTest("overwrite clears error");

      // Enough bad reads to saturate the counter
      startTest();
      pulseClear();
      a = ADDR_WIDTH'($random(seed));
      sendRequest(OP_INJECT, a, $random(seed), 1'b0);
      for (i = 0; i < N_SAT; i++) begin
         sendRequest(OP_READ, a, '0, 1'b0);
      end
      finishTest("logger saturation");
      pulseClear();

      startTest();
      clrRandom = 1'b1;
      for (i = 0; i < N_RAND; i++) begin
         a  = ADDR_WIDTH'($random(seed));
         k  = $random(seed) & 3;
         op = (k < 2) ? OP_READ : ((k == 2) ? OP_WRITE : OP_INJECT);
         if ((op == OP_READ) && !mWritten[a]) begin
            op = OP_WRITE;
         end
         sendRequest(op, a, $random(seed), ($random(seed) & 1) != 0);
      end
      clrRandom = 1'b0;
      errClear  = 1'b0;
      finishTest("random mix");

      if (pendingCnt != 0) begin
         $display("%0d requests never got a response", pendingCnt);
         tbErrors++;
      end
      $display("Done: %0d tests, %0d requests, %0d errors", testNum, totalReqs,
               chkErrors + tbErrors);
      if ((chkErrors + tbErrors) == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // Run limit from the total request count
   initial begin
      #(WATCHDOG_CYCLES * 2 * CLK_HALF);
      $display("Watchdog expired after %0d cycles, the DUT stopped responding",
               WATCHDOG_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: list.f
rtl/capPkg.sv
rtl/CapMemArray.sv
rtl/CapParityCkr.sv
rtl/CapMemCtrl.sv
rtl/CapErrLog.sv
rtl/CapMemTop.sv
sim/capChecker.sv
sim/tbCapMem.sv

// File: Makefile
# Verilator build and run for the parity-protected memory wrapper
TOP   := tbCapMem
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
